//--- list.f
source/ooo_pkg.sv
source/rs_entry_array.sv
source/rs_issue_fsm.sv
source/alu_latency_timer.sv
source/alu_exec.sv
source/rs_alu_top.sv
sim/rs_alu_assert.sv
sim/rs_alu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the reservation station testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rs_alu_tb \
  -f list.f -o sim_rs_alu > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_rs_alu > sim.log 2>&1
cat sim.log
grep -qF "** PASS **" sim.log && exit 0 || exit 1

//--- sim/rs_alu_assert.sv
module rs_alu_assert (
  input logic                  in_clk,
  input logic                  in_rst,
  input logic                  flush,
  input logic                  dispatch_valid,
  input logic                  full,
  input logic                  issue_take,
  input logic                  result_valid,
  input ooo_pkg::issue_state_t state
);

  // no result pulse while the core is held in reset
  a_no_result_in_reset: assert property (@(posedge in_clk) $past(in_rst) |-> !result_valid)
    else $error("result_valid high during reset");

  // a flush always leaves the alu idle
  a_idle_after_flush: assert property (@(posedge in_clk) disable iff (in_rst)
    flush |=> state == ooo_pkg::ISSUE_IDLE)
    else $error("issue state not idle after flush");

  // a dispatch meeting a full station must not refill the slot that issue frees
  a_no_accept_when_full: assert property (@(posedge in_clk) disable iff (in_rst)
    dispatch_valid && full && issue_take && !flush |=> !full)
    else $error("dispatch accepted while full");

endmodule

bind rs_alu_top rs_alu_assert u_assert (
  .in_clk, .in_rst, .flush, .dispatch_valid, .full, .issue_take, .result_valid,
  .state (u_issue_fsm.state)
);

//--- sim/rs_alu_tb.sv
module rs_alu_tb;

  localparam int K_DISP = 0;
  localparam int K_BC = 1;
  localparam int K_FLUSH = 2;
  localparam int K_IDLE = 3;
  localparam int K_FULL = 4;

  // one table row; bcast rows reuse dst, a, f and set as tag, value, nzcv and flag strobe
  typedef struct {
    int kind;
    ooo_pkg::alu_op_t op;
    logic ar, br, fr, set, drop;
    ooo_pkg::word_t a, b;
    ooo_pkg::nzcv_t f;
    ooo_pkg::tag_t at, bt, ft, dst;
    int n;
  } row_t;

  logic in_clk = 1'b0;
  logic in_rst = 1'b1;
  logic dispatch_valid, src_a_ready, src_b_ready, flags_ready, set_nzcv;
  logic bcast_valid, bcast_set_nzcv, flush;
  ooo_pkg::alu_op_t dispatch_op;
  ooo_pkg::word_t src_a_value, src_b_value, bcast_value;
  ooo_pkg::tag_t src_a_tag, src_b_tag, flags_tag, dst_tag, bcast_tag;
  ooo_pkg::nzcv_t flags_value, bcast_nzcv;
  logic full, result_valid, result_set_nzcv;
  ooo_pkg::tag_t result_tag;
  ooo_pkg::word_t result_value;
  ooo_pkg::nzcv_t result_nzcv;

  row_t rows[$];
  logic [31:0] lfsr = 32'hb20868b1;
  int cycles = 0;
  int limit = 1000000;

  // scoreboard, indexed by dst tag
  logic armed[32], got[32], pending[32], internal[32], exp_set[32];
  ooo_pkg::word_t exp_val[32], tag_val[32];
  ooo_pkg::nzcv_t exp_nzcv[32], tag_nzcv[32];
  int pend_row[32];

  rs_alu_top UUT (.*);

  always #50 in_clk = ~in_clk;

  task automatic stop_with(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input ooo_pkg::word_t g, input ooo_pkg::word_t e);
    if (g !== e) stop_with($sformatf("mismatch %s got %h expected %h", name, g, e));
  endtask

  task automatic check_nzcv(input string name, input ooo_pkg::nzcv_t g, input ooo_pkg::nzcv_t e);
    if (g !== e) stop_with($sformatf("mismatch %s got %h expected %h", name, g, e));
  endtask

  task automatic check_tag(input string name, input ooo_pkg::tag_t g, input ooo_pkg::tag_t e);
    if (g !== e) stop_with($sformatf("mismatch %s got %h expected %h", name, g, e));
  endtask

  task automatic check_bit(input string name, input logic g, input logic e);
    if (g !== e) stop_with($sformatf("mismatch %s got %h expected %h", name, g, e));
  endtask

  // galois lfsr, one step per bit taken
  function automatic ooo_pkg::word_t rand_bits(input int n);
    ooo_pkg::word_t v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // reference alu, returns {nzcv, value}
  function automatic logic [35:0] ref_alu(input ooo_pkg::alu_op_t op, input ooo_pkg::word_t a,
                                          input ooo_pkg::word_t b, input ooo_pkg::nzcv_t f,
                                          input logic set);
    logic [32:0] s;
    ooo_pkg::word_t r;
    logic arith, v;
    arith = (op == ooo_pkg::ADD) || (op == ooo_pkg::SUB) || (op == ooo_pkg::ADC);
    s = (op == ooo_pkg::SUB) ? {1'b0, a} + {1'b0, ~b} + 33'd1
                             : {1'b0, a} + {1'b0, b} + {32'd0, op == ooo_pkg::ADC && f[1]};
    case (op)
      ooo_pkg::AND: r = a & b;
      ooo_pkg::ORR: r = a | b;
      ooo_pkg::EOR: r = a ^ b;
      ooo_pkg::MUL: r = a * b;
      default: r = s[31:0];
    endcase
    // sub overflows when the signs differ and the result flips away from a
    v = (op == ooo_pkg::SUB) ? (a[31] != b[31]) && (r[31] != a[31])
                             : (a[31] == b[31]) && (r[31] != a[31]);
    if (!set) return {f, r};
    return {r[31], r == 32'd0, arith ? s[32] : f[1], arith ? v : f[0], r};
  endfunction

  // an entry can finish once every external wait is covered, t is the broadcast tag
  function automatic logic op_ready(input row_t r, input int t, input logic ts);
    logic needf;
    needf = r.set || r.op == ooo_pkg::ADC;
    return (r.ar || internal[r.at] || r.at == t) && (r.br || internal[r.bt] || r.bt == t)
        && (r.fr || !needf || internal[r.ft] || (r.ft == t && ts));
  endfunction

  // tag a result should carry, itself when still owed, else the lowest one still owed
  function automatic ooo_pkg::tag_t owed_tag(input ooo_pkg::tag_t t);
    ooo_pkg::tag_t w;
    w = t;
    if (!armed[t] || got[t]) begin
      for (int k = 31; k >= 0; k--) begin
        if (armed[k] && !got[k]) w = ooo_pkg::tag_t'(k);
      end
    end
    return w;
  endfunction

  task automatic arm(input int i);
    row_t r;
    logic [35:0] res;
    r = rows[i];
    res = ref_alu(r.op, r.ar ? r.a : tag_val[r.at], r.br ? r.b : tag_val[r.bt],
                  (r.fr || !(r.set || r.op == ooo_pkg::ADC)) ? r.f : tag_nzcv[r.ft], r.set);
    exp_val[r.dst] = res[31:0];
    exp_nzcv[r.dst] = res[35:32];
    exp_set[r.dst] = r.set;
    tag_val[r.dst] = res[31:0];
    if (r.set) tag_nzcv[r.dst] = res[35:32];
    armed[r.dst] = 1'b1;
    got[r.dst] = 1'b0;
  endtask

  task automatic add_op(input ooo_pkg::alu_op_t op, input logic ar, input int at,
                        input logic br, input int bt, input logic fr, input int ft,
                        input logic set, input int dst, input logic drop);
    row_t r;
    r = '{K_DISP, op, ar, br, fr, set, drop, rand_bits(32), rand_bits(32),
          ooo_pkg::nzcv_t'(rand_bits(4)), at, bt, ft, dst, 0};
    rows.push_back(r);
  endtask

  task automatic add_bc(input int tag, input logic set);
    row_t r;
    r = '{K_BC, ooo_pkg::ADD, 0, 0, 0, set, 0, rand_bits(32), 0,
          ooo_pkg::nzcv_t'(rand_bits(4)), 0, 0, 0, tag, 0};
    rows.push_back(r);
  endtask

  // idle rows use set to ask for a missing-result check, full rows for the expected flag
  task automatic add_ctl(input int kind, input int n, input logic flag);
    row_t r;
    r = '{kind, ooo_pkg::ADD, 0, 0, 0, flag, 0, 0, 0, 0, 0, 0, 0, 0, n};
    rows.push_back(r);
  endtask

  task automatic clear_inputs();
    {dispatch_valid, src_a_ready, src_b_ready, flags_ready, set_nzcv} = '0;
    {bcast_valid, bcast_set_nzcv, flush} = '0;
    dispatch_op = ooo_pkg::ADD;
    {src_a_value, src_b_value, bcast_value} = '0;
    {src_a_tag, src_b_tag, flags_tag, dst_tag, bcast_tag} = '0;
    {flags_value, bcast_nzcv} = '0;
  endtask

  always @(negedge in_clk) begin
    if (!in_rst && result_valid) begin
      if (got[result_tag]) begin
        stop_with($sformatf("duplicate result for tag %0d", result_tag));
      end else if (!armed[result_tag] && owed_tag(result_tag) == result_tag) begin
        stop_with($sformatf("unexpected result for tag %0d", result_tag));
      end else begin
        check_tag("result_tag", result_tag, owed_tag(result_tag));
        check_word("result_value", result_value, exp_val[result_tag]);
        check_nzcv("result_nzcv", result_nzcv, exp_nzcv[result_tag]);
        check_bit("result_set_nzcv", result_set_nzcv, exp_set[result_tag]);
        got[result_tag] = 1'b1;
      end
    end
  end

  always @(posedge in_clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) stop_with("timeout, the test table did not finish in time");
  end

  initial begin
    row_t r;
    clear_inputs();
    for (int t = 0; t < 32; t++) begin
      {armed[t], got[t], pending[t], internal[t], exp_set[t]} = '0;
      {tag_val[t], tag_nzcv[t]} = '0;
    end
    // independent ready ops of every opcode, plus a flag pass-through
    for (int i = 0; i < 7; i++) add_op(ooo_pkg::alu_op_t'(i), 1, 0, 1, 0, 1, 0, 1, i, 0);
    add_op(ooo_pkg::AND, 1, 0, 1, 0, 1, 0, 0, 7, 0);
    add_ctl(K_IDLE, 8, 1);
    // external wakeup, operand then flags
    add_op(ooo_pkg::ADD, 0, 28, 1, 0, 1, 0, 1, 8, 0);
    add_ctl(K_IDLE, 4, 1);
    add_bc(28, 0);
    add_ctl(K_IDLE, 4, 1);
    add_op(ooo_pkg::ADC, 1, 0, 1, 0, 0, 29, 1, 9, 0);
    add_bc(29, 0);
    add_ctl(K_IDLE, 4, 1);
    add_bc(29, 1);
    add_ctl(K_IDLE, 4, 1);
    // dependent chain through self-forwarding, mul first
    add_op(ooo_pkg::MUL, 1, 0, 1, 0, 1, 0, 1, 10, 0);
    add_op(ooo_pkg::ADD, 1, 0, 0, 10, 1, 0, 1, 11, 0);
    add_op(ooo_pkg::SUB, 0, 11, 1, 0, 0, 11, 1, 12, 0);
    add_op(ooo_pkg::EOR, 1, 0, 0, 12, 1, 0, 0, 13, 0);
    add_ctl(K_IDLE, 10, 1);
    add_op(ooo_pkg::ADC, 1, 0, 1, 0, 1, 0, 0, 14, 0);
    add_op(ooo_pkg::ORR, 1, 0, 1, 0, 1, 0, 1, 15, 0);
    add_ctl(K_IDLE, 6, 1);
    // fill the station, wake it, drop a ninth while entry 0 issues, then drain
    for (int i = 0; i < 8; i++) add_op(ooo_pkg::alu_op_t'(i % 7), 0, 27, 1, 0, 1, 0, 1, 16 + i, 0);
    add_ctl(K_FULL, 0, 1);
    add_bc(27, 0);
    add_op(ooo_pkg::ADD, 1, 0, 1, 0, 1, 0, 1, 24, 1);
    add_ctl(K_FULL, 0, 0);
    add_ctl(K_IDLE, 30, 1);
    // flush a full station with a mul in flight
    add_op(ooo_pkg::ORR, 0, 31, 1, 0, 1, 0, 1, 25, 0);
    for (int i = 0; i < 6; i++) add_op(ooo_pkg::alu_op_t'(i), 0, 31, 1, 0, 1, 0, 1, i, 0);
    add_op(ooo_pkg::MUL, 1, 0, 1, 0, 1, 0, 1, 26, 0);
    add_ctl(K_FULL, 0, 1);
    add_op(ooo_pkg::ADD, 1, 0, 0, 26, 1, 0, 1, 30, 0);
    add_ctl(K_FLUSH, 0, 0);
    add_ctl(K_FULL, 0, 0);
    add_ctl(K_IDLE, 6, 1);
    add_op(ooo_pkg::SUB, 1, 0, 1, 0, 1, 0, 1, 31, 0);
    add_ctl(K_IDLE, 6, 1);
    limit = rows.size() * (ooo_pkg::MUL_LATENCY + 4) + 200;

    repeat (4) @(posedge in_clk);
    #5 in_rst = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      clear_inputs();
      case (r.kind)
        K_DISP: begin
          dispatch_valid = 1'b1;
          dispatch_op = r.op;
          {set_nzcv, dst_tag} = {r.set, r.dst};
          {src_a_ready, src_a_value, src_a_tag} = {r.ar, r.a, r.at};
          {src_b_ready, src_b_value, src_b_tag} = {r.br, r.b, r.bt};
          {flags_ready, flags_value, flags_tag} = {r.fr, r.f, r.ft};
          if (!r.drop) begin
            if (op_ready(r, -1, 1'b0)) arm(i);
            else begin
              pending[r.dst] = 1'b1;
              pend_row[r.dst] = i;
            end
            internal[r.dst] = 1'b1;
          end
        end
        K_BC: begin
          {bcast_valid, bcast_tag, bcast_value} = {1'b1, r.dst, r.a};
          {bcast_set_nzcv, bcast_nzcv} = {r.set, r.f};
          tag_val[r.dst] = r.a;
          if (r.set) tag_nzcv[r.dst] = r.f;
          for (int t = 0; t < 32; t++) begin
            if (pending[t] && op_ready(rows[pend_row[t]], r.dst, r.set)) begin
              pending[t] = 1'b0;
              arm(pend_row[t]);
            end
          end
        end
        K_FLUSH: begin
          flush = 1'b1;
          for (int t = 0; t < 32; t++) begin
            if (armed[t] && !got[t]) armed[t] = 1'b0;
            pending[t] = 1'b0;
          end
        end
        K_FULL: check_bit("full", full, r.set);
        default: begin
          repeat (r.n - 1) @(posedge in_clk);
        end
      endcase
      @(posedge in_clk);
      #5;
      if (r.kind == K_IDLE && r.set) begin
        for (int t = 0; t < 32; t++) begin
          if (armed[t] && !got[t]) stop_with($sformatf("missing result for tag %0d", t));
        end
      end
    end
    $display("** PASS **");
    $finish;
  end

endmodule

//--- source/alu_exec.sv
module alu_exec (
  input  logic             in_clk,
  input  logic             issue_take,
  input  ooo_pkg::alu_op_t sel_op,
  input  ooo_pkg::word_t   sel_a,
  input  ooo_pkg::word_t   sel_b,
  input  ooo_pkg::nzcv_t   sel_nzcv,
  input  logic             sel_set_nzcv,
  input  ooo_pkg::tag_t    sel_dst,
  output ooo_pkg::tag_t    result_tag,
  output ooo_pkg::word_t   result_value,
  output logic             result_set_nzcv,
  output ooo_pkg::nzcv_t   result_nzcv
);

  // fields of the issued entry, held until the next issue
  ooo_pkg::alu_op_t op_q;
  ooo_pkg::word_t   a_q;
  ooo_pkg::word_t   b_q;
  ooo_pkg::nzcv_t   nzcv_q;

  // one adder serves add, sub and adc
  ooo_pkg::word_t             add_b;
  logic                       carry_in;
  logic [ooo_pkg::WORD_W:0]   sum;
  logic                       arith;
  ooo_pkg::nzcv_t             flags;

  always_ff @(posedge in_clk) begin
    if (issue_take) begin
      op_q <= sel_op;
      a_q <= sel_a;
      b_q <= sel_b;
      nzcv_q <= sel_nzcv;
      result_set_nzcv <= sel_set_nzcv;
      result_tag <= sel_dst;
    end
  end

  always_comb begin
    // sub is a + ~b + 1, so carry out means no borrow
    add_b = (op_q == ooo_pkg::SUB) ? ~b_q : b_q;
    carry_in = (op_q == ooo_pkg::SUB) || (op_q == ooo_pkg::ADC && nzcv_q[ooo_pkg::FLAG_C]);
    sum = {1'b0, a_q} + {1'b0, add_b} + {{ooo_pkg::WORD_W{1'b0}}, carry_in};
    arith = 1'b0;
    case (op_q)
      ooo_pkg::ADD, ooo_pkg::SUB, ooo_pkg::ADC: begin
        result_value = sum[ooo_pkg::WORD_W-1:0];
        arith = 1'b1;
      end
      ooo_pkg::AND: result_value = a_q & b_q;
      ooo_pkg::ORR: result_value = a_q | b_q;
      ooo_pkg::EOR: result_value = a_q ^ b_q;
      // low half of the product
      ooo_pkg::MUL: result_value = a_q * b_q;
      default: result_value = '0;
    endcase
    flags[ooo_pkg::FLAG_N] = result_value[ooo_pkg::WORD_W-1];
    flags[ooo_pkg::FLAG_Z] = (result_value == '0);
    // logical ops and mul keep c and v of the flag operand
    flags[ooo_pkg::FLAG_C] = arith ? sum[ooo_pkg::WORD_W] : nzcv_q[ooo_pkg::FLAG_C];
    // overflow when both addends agree in sign and the sum does not
    flags[ooo_pkg::FLAG_V] = arith ? (a_q[ooo_pkg::WORD_W-1] == add_b[ooo_pkg::WORD_W-1])
                                     && (result_value[ooo_pkg::WORD_W-1] != a_q[ooo_pkg::WORD_W-1])
                                   : nzcv_q[ooo_pkg::FLAG_V];
  end

  // without set_nzcv the flag operand travels on unchanged
  assign result_nzcv = result_set_nzcv ? flags : nzcv_q;

endmodule

//--- source/alu_latency_timer.sv
module alu_latency_timer (
  input  logic             in_clk,
  input  logic             in_rst,
  input  logic             flush,
  input  logic             issue_take,
  input  ooo_pkg::alu_op_t sel_op,
  output logic             timer_done
);

  // cycles left until the result is due, zero when the alu is empty
  ooo_pkg::lat_t count;
  ooo_pkg::lat_t load_val;

  // mul is the only multi-cycle operation
  assign load_val = (sel_op == ooo_pkg::MUL) ? ooo_pkg::MUL_LATENCY
                                             : ooo_pkg::BASE_LATENCY;

  always_ff @(posedge in_clk) begin
    if (in_rst || flush) begin
      count <= '0;
    end else if (issue_take) begin
      // reload wins over the decrement for back-to-back issue
      count <= load_val;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // last busy cycle, a load only lands at the edge closing it
  assign timer_done = (count == ooo_pkg::lat_t'(1));

endmodule

//--- source/ooo_pkg.sv
package ooo_pkg;

  // data, tag and flag widths
  localparam int WORD_W = 32;
  localparam int TAG_W = 5;
  localparam int NZCV_W = 4;

  // reservation station geometry
  localparam int RS_SIZE = 8;
  localparam int RS_IDX_W = 3;

  // bit positions inside nzcv_t, n is the msb
  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  typedef logic [WORD_W-1:0] word_t;
  // rob tag of the producer of a value
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [NZCV_W-1:0] nzcv_t;
  typedef logic [RS_IDX_W-1:0] rs_idx_t;
  // execution latency count, wide enough for the mul latency
  typedef logic [1:0] lat_t;

  // cycles from issue to result
  localparam lat_t MUL_LATENCY = 2'd3;
  localparam lat_t BASE_LATENCY = 2'd1;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    ADC,
    AND,
    ORR,
    EOR,
    MUL
  } alu_op_t;

  // idle, or an operation in the alu waiting for its timer
  typedef enum logic {
    ISSUE_IDLE,
    ISSUE_EXEC
  } issue_state_t;

endpackage

//--- source/rs_alu_top.sv
module rs_alu_top (
  input  logic             in_clk,
  input  logic             in_rst,
  input  logic             dispatch_valid,
  input  ooo_pkg::alu_op_t dispatch_op,
  input  logic             src_a_ready,
  input  ooo_pkg::word_t   src_a_value,
  input  ooo_pkg::tag_t    src_a_tag,
  input  logic             src_b_ready,
  input  ooo_pkg::word_t   src_b_value,
  input  ooo_pkg::tag_t    src_b_tag,
  input  logic             flags_ready,
  input  ooo_pkg::nzcv_t   flags_value,
  input  ooo_pkg::tag_t    flags_tag,
  input  logic             set_nzcv,
  input  ooo_pkg::tag_t    dst_tag,
  input  logic             bcast_valid,
  input  ooo_pkg::tag_t    bcast_tag,
  input  ooo_pkg::word_t   bcast_value,
  input  logic             bcast_set_nzcv,
  input  ooo_pkg::nzcv_t   bcast_nzcv,
  input  logic             flush,
  output logic             full,
  output logic             result_valid,
  output ooo_pkg::tag_t    result_tag,
  output ooo_pkg::word_t   result_value,
  output logic             result_set_nzcv,
  output ooo_pkg::nzcv_t   result_nzcv
);

  // selected entry on its way to the alu
  logic             ready_any;
  logic             issue_take;
  logic             timer_done;
  ooo_pkg::alu_op_t sel_op;
  ooo_pkg::word_t   sel_a;
  ooo_pkg::word_t   sel_b;
  ooo_pkg::nzcv_t   sel_nzcv;
  logic             sel_set_nzcv;
  ooo_pkg::tag_t    sel_dst;

  // result is only valid in the last busy cycle of the alu
  assign result_valid = timer_done;

  // own result wakes dependents on the second port
  rs_entry_array u_entry_array (
    .*,
    .res_valid    (result_valid),
    .res_tag      (result_tag),
    .res_value    (result_value),
    .res_set_nzcv (result_set_nzcv),
    .res_nzcv     (result_nzcv)
  );

  rs_issue_fsm u_issue_fsm (.*);

  alu_latency_timer u_latency_timer (.*);

  alu_exec u_alu_exec (.*);

endmodule

//--- source/rs_entry_array.sv
module rs_entry_array (
  input  logic             in_clk,
  input  logic             in_rst,
  input  logic             flush,
  input  logic             dispatch_valid,
  input  ooo_pkg::alu_op_t dispatch_op,
  input  logic             src_a_ready,
  input  ooo_pkg::word_t   src_a_value,
  input  ooo_pkg::tag_t    src_a_tag,
  input  logic             src_b_ready,
  input  ooo_pkg::word_t   src_b_value,
  input  ooo_pkg::tag_t    src_b_tag,
  input  logic             flags_ready,
  input  ooo_pkg::nzcv_t   flags_value,
  input  ooo_pkg::tag_t    flags_tag,
  input  logic             set_nzcv,
  input  ooo_pkg::tag_t    dst_tag,
  input  logic             bcast_valid,
  input  ooo_pkg::tag_t    bcast_tag,
  input  ooo_pkg::word_t   bcast_value,
  input  logic             bcast_set_nzcv,
  input  ooo_pkg::nzcv_t   bcast_nzcv,
  input  logic             res_valid,
  input  ooo_pkg::tag_t    res_tag,
  input  ooo_pkg::word_t   res_value,
  input  logic             res_set_nzcv,
  input  ooo_pkg::nzcv_t   res_nzcv,
  input  logic             issue_take,
  output logic             full,
  output logic             ready_any,
  output ooo_pkg::alu_op_t sel_op,
  output ooo_pkg::word_t   sel_a,
  output ooo_pkg::word_t   sel_b,
  output ooo_pkg::nzcv_t   sel_nzcv,
  output logic             sel_set_nzcv,
  output ooo_pkg::tag_t    sel_dst
);

  // occupancy and per-operand ready bits
  logic [ooo_pkg::RS_SIZE-1:0] ent_valid;
  logic [ooo_pkg::RS_SIZE-1:0] a_rdy;
  logic [ooo_pkg::RS_SIZE-1:0] b_rdy;
  logic [ooo_pkg::RS_SIZE-1:0] f_rdy;
  logic [ooo_pkg::RS_SIZE-1:0] ent_ready;

  // entry payload
  ooo_pkg::alu_op_t ent_op [ooo_pkg::RS_SIZE];
  ooo_pkg::word_t   a_val [ooo_pkg::RS_SIZE];
  ooo_pkg::tag_t    a_tag [ooo_pkg::RS_SIZE];
  ooo_pkg::word_t   b_val [ooo_pkg::RS_SIZE];
  ooo_pkg::tag_t    b_tag [ooo_pkg::RS_SIZE];
  ooo_pkg::nzcv_t   f_val [ooo_pkg::RS_SIZE];
  ooo_pkg::tag_t    f_tag [ooo_pkg::RS_SIZE];
  logic             ent_set_nzcv [ooo_pkg::RS_SIZE];
  ooo_pkg::tag_t    ent_dst [ooo_pkg::RS_SIZE];

  ooo_pkg::rs_idx_t free_idx;
  ooo_pkg::rs_idx_t sel_idx;
  logic             accept;
  logic             flags_in_rdy;

  // tag match on one port for an operand still waiting
  function automatic logic wake_hit(input logic rdy, input ooo_pkg::tag_t want,
                                    input logic port_valid, input ooo_pkg::tag_t port_tag);
    return !rdy && port_valid && (want == port_tag);
  endfunction

  // operand value after both ports, the alu result port is applied last so it wins
  function automatic ooo_pkg::word_t pick_word(input logic rdy, input ooo_pkg::tag_t want,
                                               input ooo_pkg::word_t cur);
    pick_word = cur;
    if (wake_hit(rdy, want, bcast_valid, bcast_tag)) pick_word = bcast_value;
    if (wake_hit(rdy, want, res_valid, res_tag)) pick_word = res_value;
  endfunction

  function automatic logic word_woken(input logic rdy, input ooo_pkg::tag_t want);
    return rdy || wake_hit(rdy, want, bcast_valid, bcast_tag)
               || wake_hit(rdy, want, res_valid, res_tag);
  endfunction

  // flags only wake from a producer that actually writes nzcv
  function automatic ooo_pkg::nzcv_t pick_flags(input logic rdy, input ooo_pkg::tag_t want,
                                                input ooo_pkg::nzcv_t cur);
    pick_flags = cur;
    if (wake_hit(rdy, want, bcast_valid && bcast_set_nzcv, bcast_tag)) pick_flags = bcast_nzcv;
    if (wake_hit(rdy, want, res_valid && res_set_nzcv, res_tag)) pick_flags = res_nzcv;
  endfunction

  function automatic logic flags_woken(input logic rdy, input ooo_pkg::tag_t want);
    return rdy || wake_hit(rdy, want, bcast_valid && bcast_set_nzcv, bcast_tag)
               || wake_hit(rdy, want, res_valid && res_set_nzcv, res_tag);
  endfunction

  assign full = &ent_valid;
  assign accept = dispatch_valid && !full && !flush;
  // no flag operand needed unless flags are written or adc reads carry
  assign flags_in_rdy = flags_ready || !(set_nzcv || dispatch_op == ooo_pkg::ADC);

  always_comb begin
    for (int i = 0; i < ooo_pkg::RS_SIZE; i++) begin
      ent_ready[i] = ent_valid[i] && a_rdy[i] && b_rdy[i] && f_rdy[i];
    end
  end
  assign ready_any = |ent_ready;

  // lowest free and lowest ready entry, scanned from the top down
  always_comb begin
    free_idx = '0;
    sel_idx = '0;
    for (int i = ooo_pkg::RS_SIZE - 1; i >= 0; i--) begin
      if (!ent_valid[i]) begin
        free_idx = ooo_pkg::rs_idx_t'(i);
      end
      if (ent_ready[i]) begin
        sel_idx = ooo_pkg::rs_idx_t'(i);
      end
    end
  end

  assign sel_op = ent_op[sel_idx];
  assign sel_a = a_val[sel_idx];
  assign sel_b = b_val[sel_idx];
  assign sel_nzcv = f_val[sel_idx];
  assign sel_set_nzcv = ent_set_nzcv[sel_idx];
  assign sel_dst = ent_dst[sel_idx];

  // free and allocated entries never coincide
  always_ff @(posedge in_clk) begin
    if (in_rst || flush) begin
      ent_valid <= '0;
    end else begin
      if (issue_take) begin
        ent_valid[sel_idx] <= 1'b0;
      end
      if (accept) begin
        ent_valid[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    // wakeup of resident entries
    for (int i = 0; i < ooo_pkg::RS_SIZE; i++) begin
      if (ent_valid[i]) begin
        a_val[i] <= pick_word(a_rdy[i], a_tag[i], a_val[i]);
        a_rdy[i] <= word_woken(a_rdy[i], a_tag[i]);
        b_val[i] <= pick_word(b_rdy[i], b_tag[i], b_val[i]);
        b_rdy[i] <= word_woken(b_rdy[i], b_tag[i]);
        f_val[i] <= pick_flags(f_rdy[i], f_tag[i], f_val[i]);
        f_rdy[i] <= flags_woken(f_rdy[i], f_tag[i]);
      end
    end
    // allocation, a producer finishing in the accept cycle is caught here too
    if (accept) begin
      ent_op[free_idx] <= dispatch_op;
      ent_set_nzcv[free_idx] <= set_nzcv;
      ent_dst[free_idx] <= dst_tag;
      a_tag[free_idx] <= src_a_tag;
      b_tag[free_idx] <= src_b_tag;
      f_tag[free_idx] <= flags_tag;
      a_val[free_idx] <= pick_word(src_a_ready, src_a_tag, src_a_value);
      a_rdy[free_idx] <= word_woken(src_a_ready, src_a_tag);
      b_val[free_idx] <= pick_word(src_b_ready, src_b_tag, src_b_value);
      b_rdy[free_idx] <= word_woken(src_b_ready, src_b_tag);
      f_val[free_idx] <= pick_flags(flags_in_rdy, flags_tag, flags_value);
      f_rdy[free_idx] <= flags_woken(flags_in_rdy, flags_tag);
    end
  end

endmodule

//--- source/rs_issue_fsm.sv
module rs_issue_fsm (
  input  logic in_clk,
  input  logic in_rst,
  input  logic flush,
  input  logic ready_any,
  input  logic timer_done,
  output logic issue_take
);

  ooo_pkg::issue_state_t state;
  ooo_pkg::issue_state_t state_next;

  // the alu accepts a new operation when idle or in its last busy cycle
  logic alu_free;

  assign alu_free = (state == ooo_pkg::ISSUE_IDLE) || timer_done;

  // flush cancels any issue in the same cycle
  assign issue_take = ready_any && !flush && alu_free;

  always_comb begin
    state_next = state;
    case (state)
      ooo_pkg::ISSUE_IDLE: begin
        if (issue_take) begin
          state_next = ooo_pkg::ISSUE_EXEC;
        end
      end
      ooo_pkg::ISSUE_EXEC: begin
        // back-to-back issue keeps the alu busy
        if (timer_done && !issue_take) begin
          state_next = ooo_pkg::ISSUE_IDLE;
        end
      end
      default: begin
        state_next = ooo_pkg::ISSUE_IDLE;
      end
    endcase
    // misprediction drops the operation in flight
    if (flush) begin
      state_next = ooo_pkg::ISSUE_IDLE;
    end
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      state <= ooo_pkg::ISSUE_IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule
